// ==== source/dram_pkg.sv ====
// Shared DRAM subsystem definitions: word and address widths, sizes and FSM encodings.

package dram_pkg;

	// ==========================================================================
	// sizes
	// ==========================================================================

	localparam int MEM_WORDS   = 1024; // words in the shared memory.
	localparam int FETCH_WORDS = 16;   // words fetched per video line.
	localparam int FIFO_DEPTH  = 8;    // pixel FIFO entries, a power of two.

	localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
	localparam int FETCH_CNT_W = $clog2(FETCH_WORDS + 1);

	// ==========================================================================
	// types
	// ==========================================================================

	typedef logic [$clog2(MEM_WORDS)-1:0]    dram_addr_t;  // word address.
	typedef logic [15:0]                     dram_word_t;  // one memory word.
	typedef logic [1:0]                      byte_sel_t;   // bit 0 enables the low byte.
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_t; // holds 0 to FIFO_DEPTH.

	// access slot phases, one clock each.
	typedef enum logic [1:0] {
		SLOT_C0,
		SLOT_C1,
		SLOT_C2,
		SLOT_C3
	} slot_t;

	typedef enum logic {
		FETCH_IDLE,
		FETCH_RUN
	} fetch_state_t;

endpackage

// ==== source/dram_interfaces.sv ====
// Bundles between the arbiter and the memory and between the video fetcher and the arbiter.

`timescale 1ns/10ps

interface dram_port_if;

	dram_pkg::dram_addr_t addr;
	logic                 req;    // one-cycle request in slot phase c0.
	logic                 rnw;    // high for a read.
	dram_pkg::dram_word_t wrdata;
	dram_pkg::byte_sel_t  bsel;
	dram_pkg::dram_word_t rddata; // valid while done is high.
	logic                 done;

	modport master (
		output addr, req, rnw, wrdata, bsel,
		input  rddata, done
	);

	modport slave (
		input  addr, req, rnw, wrdata, bsel,
		output rddata, done
	);

endinterface

interface video_port_if;

	dram_pkg::dram_addr_t video_addr;
	logic                 video_go;     // held high while a word is wanted.
	logic                 video_next;   // video_addr taken for the next slot.
	logic                 video_strobe; // video_data is valid.
	dram_pkg::dram_word_t video_data;

	modport requester (
		output video_addr, video_go,
		input  video_next, video_strobe, video_data
	);

	modport server (
		input  video_addr, video_go,
		output video_next, video_strobe, video_data
	);

endinterface

// ==== source/dram_controller.sv ====
// Slot-timed word memory that performs one read or one byte-selected write per slot.

`timescale 1ns/10ps

module dram_controller (
	input logic         clk,
	input logic         reset,
	dram_port_if.slave  port
);

	dram_pkg::dram_word_t mem_array [dram_pkg::MEM_WORDS];

	dram_pkg::slot_t      slot;

	logic                 acc_valid;
	logic                 acc_rnw;
	dram_pkg::dram_addr_t acc_addr;
	dram_pkg::dram_word_t acc_wrdata;
	dram_pkg::byte_sel_t  acc_bsel;

	// ==========================================================================
	// slot phase, kept in step with the arbiter since both start at c0
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
			slot <= dram_pkg::SLOT_C0;
		else
			slot <= dram_pkg::slot_t'(slot + 2'd1);
	end

	// ==========================================================================
	// access control
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc_valid <= 1'b0;
			port.done <= 1'b0;
		end
		else
		begin
			if (slot == dram_pkg::SLOT_C0)
				acc_valid <= port.req; // request is only looked at in c0.
			port.done <= (slot == dram_pkg::SLOT_C1) && acc_valid; // high during c2.
		end
	end

	always_ff @(posedge clk)
	begin
		if (slot == dram_pkg::SLOT_C0 && port.req)
		begin
			acc_rnw    <= port.rnw;
			acc_addr   <= port.addr;
			acc_wrdata <= port.wrdata;
			acc_bsel   <= port.bsel;
		end
	end

	// ==========================================================================
	// array access in c1
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (slot == dram_pkg::SLOT_C1 && acc_valid)
		begin
			if (acc_rnw)
				port.rddata <= mem_array[acc_addr];
			else
			begin
				if (acc_bsel[0])
					mem_array[acc_addr][7:0] <= acc_wrdata[7:0];
				if (acc_bsel[1])
					mem_array[acc_addr][15:8] <= acc_wrdata[15:8];
			end
		end
	end

endmodule

// ==== source/dram_arbiter.sv ====
// Slot arbiter that shares memory slots between video fetch and the CPU port.

`timescale 1ns/10ps

module dram_arbiter (
	input  logic                 clk,
	input  logic                 reset,
	dram_port_if.master          mem,
	video_port_if.server         video,
	input  logic                 cpu_req,
	input  logic                 cpu_rnw,
	input  dram_pkg::dram_addr_t cpu_addr,
	input  dram_pkg::dram_word_t cpu_wrdata,
	input  dram_pkg::byte_sel_t  cpu_bsel,
	output dram_pkg::dram_word_t cpu_rddata,
	output logic                 cpu_strobe
);

	dram_pkg::slot_t slot;

	logic owner_video; // owner of the slot in flight, also the last one served.
	logic cpu_served;
	logic want_video;
	logic want_cpu;
	logic grant_video;
	logic grant_cpu;

	always_ff @(posedge clk)
	begin
		if (reset)
			slot <= dram_pkg::SLOT_C0;
		else
			slot <= dram_pkg::slot_t'(slot + 2'd1);
	end

	// ==========================================================================
	// grant at c3, alternating when both sides ask
	// ==========================================================================

	always_comb
	begin
		want_video  = video.video_go;
		want_cpu    = cpu_req && !cpu_served;
		grant_video = 1'b0;
		grant_cpu   = 1'b0;
		if (slot == dram_pkg::SLOT_C3)
		begin
			if (want_video && want_cpu)
			begin
				grant_video = !owner_video;
				grant_cpu   = owner_video;
			end
			else
			begin
				grant_video = want_video;
				grant_cpu   = want_cpu;
			end
		end
	end

	assign video.video_next = grant_video; // fetcher steps its address on this edge.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mem.req     <= 1'b0;
			owner_video <= 1'b0;
			cpu_served  <= 1'b0;
		end
		else
		begin
			mem.req <= grant_video || grant_cpu; // high for the c0 cycle only.
			if (grant_video || grant_cpu)
				owner_video <= grant_video;
			if (!cpu_req)
				cpu_served <= 1'b0; // the CPU has let go, a new request may follow.
			else if (cpu_strobe)
				cpu_served <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_video)
		begin
			mem.rnw  <= 1'b1;
			mem.addr <= video.video_addr;
			mem.bsel <= '0;
		end
		else if (grant_cpu)
		begin
			mem.rnw    <= cpu_rnw;
			mem.addr   <= cpu_addr;
			mem.wrdata <= cpu_wrdata;
			mem.bsel   <= cpu_bsel;
		end
	end

	// ==========================================================================
	// result routing
	// ==========================================================================

	assign cpu_strobe         = mem.done && !owner_video;
	assign video.video_strobe = mem.done && owner_video;
	assign cpu_rddata         = mem.rddata;
	assign video.video_data   = mem.rddata;

endmodule

// ==== source/video_fetch.sv ====
// Video line fetcher that reads one line of words and pushes them into the pixel FIFO.

`timescale 1ns/10ps

module video_fetch (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  line_start,
	input  dram_pkg::dram_addr_t  line_base,
	video_port_if.requester       video,
	input  dram_pkg::fifo_count_t fifo_free,
	output logic                  push,
	output dram_pkg::dram_word_t  push_data
);

	dram_pkg::fetch_state_t           state;
	dram_pkg::dram_addr_t             addr;
	logic [dram_pkg::FETCH_CNT_W-1:0] remaining;
	logic                             in_flight;
	logic                             has_space;

	// a word in flight already owns one free entry.
	assign has_space = fifo_free >
		(in_flight ? dram_pkg::fifo_count_t'(2) : dram_pkg::fifo_count_t'(1));

	assign video.video_go   = (state == dram_pkg::FETCH_RUN) && (remaining != '0) && has_space;
	assign video.video_addr = addr;

	// ==========================================================================
	// line FSM
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= dram_pkg::FETCH_IDLE;
			remaining <= '0;
			in_flight <= 1'b0;
		end
		else
		begin
			case (state)
				dram_pkg::FETCH_IDLE:
				begin
					if (line_start)
					begin
						state     <= dram_pkg::FETCH_RUN;
						remaining <= dram_pkg::FETCH_CNT_W'(dram_pkg::FETCH_WORDS);
					end
				end
				dram_pkg::FETCH_RUN:
				begin
					// line_start is not looked at here, so a restart is ignored.
					if (video.video_next)
					begin
						remaining <= remaining - 1'b1;
						in_flight <= 1'b1;
					end
					else if (video.video_strobe)
						in_flight <= 1'b0;
					if (remaining == '0 && !in_flight)
						state <= dram_pkg::FETCH_IDLE;
				end
				default: state <= dram_pkg::FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == dram_pkg::FETCH_IDLE && line_start)
			addr <= line_base;
		else if (video.video_next)
			addr <= addr + 1'b1;
	end

	assign push      = video.video_strobe;
	assign push_data = video.video_data;

endmodule

// ==== source/pixel_fifo.sv ====
// Word FIFO between the video fetcher and the pixel port, with a free-space count.

`timescale 1ns/10ps

module pixel_fifo (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  push,
	input  dram_pkg::dram_word_t  push_data,
	output dram_pkg::fifo_count_t free,
	output logic                  pixel_valid,
	output dram_pkg::dram_word_t  pixel_data,
	input  logic                  pixel_ready
);

	dram_pkg::dram_word_t            fifo_mem [dram_pkg::FIFO_DEPTH];
	logic [dram_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [dram_pkg::FIFO_PTR_W-1:0] rd_ptr;
	dram_pkg::fifo_count_t           count;
	logic                            wr_en;
	logic                            rd_en;

	assign wr_en       = push && (count != dram_pkg::fifo_count_t'(dram_pkg::FIFO_DEPTH));
	assign rd_en       = pixel_valid && pixel_ready;
	assign pixel_valid = count != '0;
	assign pixel_data  = fifo_mem[rd_ptr]; // oldest word, held until taken.
	assign free        = dram_pkg::fifo_count_t'(dram_pkg::FIFO_DEPTH) - count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, pointers wrap.
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			fifo_mem[wr_ptr] <= push_data;
	end

endmodule

// ==== source/video_dram_top.sv ====
// Shared DRAM subsystem top level joining the CPU port, the video fetch and the pixel port.

`timescale 1ns/10ps

module video_dram_top (
	input  logic                 clk,
	input  logic                 reset,

	input  logic                 cpu_req,
	input  logic                 cpu_rnw,
	input  dram_pkg::dram_addr_t cpu_addr,
	input  dram_pkg::dram_word_t cpu_wrdata,
	input  dram_pkg::byte_sel_t  cpu_bsel,
	output dram_pkg::dram_word_t cpu_rddata,
	output logic                 cpu_strobe,

	input  logic                 line_start,
	input  dram_pkg::dram_addr_t line_base,

	output logic                 pixel_valid,
	output dram_pkg::dram_word_t pixel_data,
	input  logic                 pixel_ready
);

	dram_pkg::fifo_count_t fifo_free;
	logic                  push;
	dram_pkg::dram_word_t  push_data;

	dram_port_if  mem_bus ();
	video_port_if video_bus ();

	dram_controller u_controller (
		.clk        (clk),
		.reset      (reset),
		.port       (mem_bus)
	);

	dram_arbiter u_arbiter (
		.clk        (clk),
		.reset      (reset),
		.mem        (mem_bus),
		.video      (video_bus),
		.cpu_req    (cpu_req),
		.cpu_rnw    (cpu_rnw),
		.cpu_addr   (cpu_addr),
		.cpu_wrdata (cpu_wrdata),
		.cpu_bsel   (cpu_bsel),
		.cpu_rddata (cpu_rddata),
		.cpu_strobe (cpu_strobe)
	);

	video_fetch u_fetch (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.line_base  (line_base),
		.video      (video_bus),
		.fifo_free  (fifo_free),
		.push       (push),
		.push_data  (push_data)
	);

	pixel_fifo u_fifo (
		.clk         (clk),
		.reset       (reset),
		.push        (push),
		.push_data   (push_data),
		.free        (fifo_free),
		.pixel_valid (pixel_valid),
		.pixel_data  (pixel_data),
		.pixel_ready (pixel_ready)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset source with a 10 ns clock and reset held for 10 cycles.

`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0; // released just after an edge, like the other inputs.
	end

endmodule

// ==== verification/tb_video_dram.sv ====
// Testbench for the shared DRAM subsystem, driven from a case file and a memory model.

`timescale 1ns/10ps

module tb_video_dram;

	localparam int DRIVE_DELAY   = 1;
	localparam int CPU_TIMEOUT   = 40;
	localparam int CPU_MAX_WAIT  = 11;
	localparam int LINE_TIMEOUT  = 400;
	localparam int HOLD_CYCLES   = 80;
	localparam int RESTART_CYCLE = 20;
	localparam int TAIL_CYCLES   = 30;

	logic                 clk;
	logic                 reset;
	logic                 cpu_req;
	logic                 cpu_rnw;
	dram_pkg::dram_addr_t cpu_addr;
	dram_pkg::dram_word_t cpu_wrdata;
	dram_pkg::byte_sel_t  cpu_bsel;
	dram_pkg::dram_word_t cpu_rddata;
	logic                 cpu_strobe;
	logic                 line_start;
	dram_pkg::dram_addr_t line_base;
	logic                 pixel_valid;
	dram_pkg::dram_word_t pixel_data;
	logic                 pixel_ready;

	dram_pkg::dram_word_t model [dram_pkg::MEM_WORDS]; // expected memory contents.
	logic [31:0]          lcg_state;
	int                   errors;
	int                   timeouts;

	tb_clock_gen clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	video_dram_top DUT (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_rnw     (cpu_rnw),
		.cpu_addr    (cpu_addr),
		.cpu_wrdata  (cpu_wrdata),
		.cpu_bsel    (cpu_bsel),
		.cpu_rddata  (cpu_rddata),
		.cpu_strobe  (cpu_strobe),
		.line_start  (line_start),
		.line_base   (line_base),
		.pixel_valid (pixel_valid),
		.pixel_data  (pixel_data),
		.pixel_ready (pixel_ready)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic model_write(input dram_pkg::dram_addr_t addr,
		input dram_pkg::dram_word_t data, input dram_pkg::byte_sel_t bsel);
		if (bsel[0])
			model[addr][7:0] = data[7:0];
		if (bsel[1])
			model[addr][15:8] = data[15:8];
	endtask

	// ==========================================================================
	// CPU port access, held until cpu_strobe
	// ==========================================================================

	task automatic cpu_access(input logic rnw, input dram_pkg::dram_addr_t addr,
		input dram_pkg::dram_word_t data, input dram_pkg::byte_sel_t bsel,
		input string name, output dram_pkg::dram_word_t rdata);
		int   cycles;
		logic strobe_seen;
		@(posedge clk);
		#DRIVE_DELAY;
		cpu_req     = 1'b1;
		cpu_rnw     = rnw;
		cpu_addr    = addr;
		cpu_wrdata  = data;
		cpu_bsel    = bsel;
		cycles      = 0;
		strobe_seen = 1'b0;
		while (!strobe_seen && cycles < CPU_TIMEOUT)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
			strobe_seen = cpu_strobe;
		end
		rdata   = cpu_rddata; // read data belongs to the strobe cycle.
		cpu_req = 1'b0;
		assert (strobe_seen)
		else
		begin
			$display("%s: cpu_strobe did not arrive within %0d cycles", name, CPU_TIMEOUT);
			timeouts++;
		end
		if (strobe_seen)
		begin
			assert (cycles <= CPU_MAX_WAIT)
			else
			begin
				$display("FAILED %s latency: expected at most %0d, actual %0d",
					name, CPU_MAX_WAIT, cycles);
				errors++;
			end
		end
	endtask

	// ==========================================================================
	// line fetch and pixel port
	// ==========================================================================

	// mode 0 always ready, 1 held off first, 2 LCG throttled, 3 ready with a restart pulse.
	task automatic run_line(input dram_pkg::dram_addr_t base, input int mode, input string name);
		int                   got;
		int                   cycles;
		logic                 held_seen;
		dram_pkg::dram_word_t held_word;
		dram_pkg::dram_addr_t word_addr;
		@(posedge clk);
		#DRIVE_DELAY;
		line_base  = base;
		line_start = 1'b1;
		got        = 0;
		cycles     = 0;
		held_seen  = 1'b0;
		held_word  = '0;
		while (got < dram_pkg::FETCH_WORDS && cycles < LINE_TIMEOUT)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
			line_start = (mode == 3) && (cycles == RESTART_CYCLE);
			if (line_start)
				line_base = base ^ 10'h080; // a restart that took effect would show other words.
			case (mode)
				1: pixel_ready = (cycles > HOLD_CYCLES);
				2:
				begin
					lcg_state   = lcg_next(lcg_state);
					pixel_ready = lcg_state[20];
				end
				default: pixel_ready = 1'b1;
			endcase
			if (mode == 1 && !pixel_ready)
			begin
				if (held_seen)
				begin
					assert (pixel_valid && pixel_data == held_word)
					else
					begin
						$display("FAILED %s held word: expected %h, actual %h (valid %b)",
							name, held_word, pixel_data, pixel_valid);
						errors++;
					end
				end
				else if (pixel_valid)
				begin
					held_seen = 1'b1;
					held_word = pixel_data;
				end
			end
			if (pixel_valid && pixel_ready)
			begin
				word_addr = base + dram_pkg::dram_addr_t'(got);
				assert (pixel_data == model[word_addr])
				else
				begin
					$display("FAILED %s word %0d: expected %h, actual %h",
						name, got, model[word_addr], pixel_data);
					errors++;
				end
				got++;
			end
		end
		assert (got == dram_pkg::FETCH_WORDS)
		else
		begin
			$display("%s: line stopped after %0d of %0d words", name, got, dram_pkg::FETCH_WORDS);
			timeouts++;
		end
		line_start  = 1'b0;
		pixel_ready = 1'b1;
		repeat (TAIL_CYCLES)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			assert (!pixel_valid)
			else
			begin
				$display("FAILED %s extra word: expected none, actual %h", name, pixel_data);
				errors++;
			end
		end
	endtask

	task automatic run_case(input logic [7:0] op, input logic [31:0] a, b, c, d,
		input int line_no);
		string                name;
		dram_pkg::dram_word_t rdata;
		name = $sformatf("case line %0d (%c)", line_no, op);
		case (op)
			"W":
			begin
				cpu_access(1'b0, a[9:0], b[15:0], c[1:0], name, rdata);
				model_write(a[9:0], b[15:0], c[1:0]);
			end
			"R":
			begin
				cpu_access(1'b1, a[9:0], 16'h0000, 2'b00, name, rdata);
				assert (rdata == b[15:0])
				else
				begin
					$display("FAILED %s read: expected %h, actual %h", name, b[15:0], rdata);
					errors++;
				end
			end
			"L": run_line(a[9:0], int'(b), name);
			"C":
			begin
				fork
					run_line(a[9:0], 0, name);
					begin
						repeat (12) @(posedge clk); // lets the fetch get going first.
						cpu_access(!d[0], b[9:0], c[15:0], 2'b11, name, rdata);
						if (d[0])
							model_write(b[9:0], c[15:0], 2'b11);
						else
						begin
							assert (rdata == c[15:0])
							else
							begin
								$display("FAILED %s shared read: expected %h, actual %h",
									name, c[15:0], rdata);
								errors++;
							end
						end
					end
				join
			end
			default:
			begin
				$display("%s: unknown operation in the case file", name);
				errors++;
			end
		endcase
	endtask

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial
	begin
		int          fd;
		int          n;
		int          line_no;
		int          cycles;
		string       text;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		errors      = 0;
		timeouts    = 0;
		lcg_state   = 32'h8c63_af09;
		cpu_req     = 1'b0;
		cpu_rnw     = 1'b1;
		cpu_addr    = '0;
		cpu_wrdata  = '0;
		cpu_bsel    = '0;
		line_start  = 1'b0;
		line_base   = '0;
		pixel_ready = 1'b0;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (reset && cycles < 50);
		assert (!reset)
		else
		begin
			$display("reset was never released");
			timeouts++;
		end
		repeat (20)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			assert (!cpu_strobe && !pixel_valid)
			else
			begin
				$display("FAILED reset state: expected strobe 0 valid 0, actual strobe %b valid %b",
					cpu_strobe, pixel_valid);
				errors++;
			end
		end
		fd = $fopen("verification/video_dram_cases.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("the case file could not be opened");
			errors++;
		end
		line_no = 0;
		while (fd != 0 && !$feof(fd))
		begin
			text = "";
			n = $fgets(text, fd);
			line_no++;
			n = $sscanf(text, "%c %h %h %h %h", op, a, b, c, d);
			if (n == 5 && op != "#")
				run_case(op, a, b, c, d, line_no);
		end
		if (fd != 0)
			$fclose(fd);
		$display("checks done with %0d value errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
source/dram_pkg.sv
source/dram_interfaces.sv
source/dram_controller.sv
source/dram_arbiter.sv
source/video_fetch.sv
source/pixel_fifo.sv
source/video_dram_top.sv
verification/tb_clock_gen.sv
verification/tb_video_dram.sv

// ==== Makefile ====
# Build and run the shared DRAM testbench with Verilator.

VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_video_dram
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/video_dram_cases.txt ====
# op a b c d in hex. W addr data bsel 0, R addr expected 0 0, C base addr word kind (0 read, 1 write)
# L base mode 0 0 with mode 0 always ready, 1 held off, 2 LCG throttled, 3 restart pulse
W 100 c3a0 3 0
W 101 4e11 3 0
W 102 9b52 3 0
W 103 07e3 3 0
W 104 d214 3 0
W 105 1234 3 0
W 106 6f86 3 0
W 107 a0c7 3 0
W 108 3d58 3 0
W 109 e219 3 0
W 10a 58fa 3 0
W 10b b37b 3 0
W 10c 0c9c 3 0
W 10d 719d 3 0
W 10e fa2e 3 0
W 10f 2b6f 3 0
W 105 abcd 1 0
R 105 12cd 0 0
W 105 ef00 2 0
R 105 efcd 0 0
L 100 0 0 0
L 100 1 0 0
L 100 2 0 0
L 100 3 0 0
C 100 10a 58fa 0
C 100 1f0 beef 1
R 1f0 beef 0 0
